// ==== design/file_dumper.sv ====
// send side of the file port
// header SOH id EOT SOT, one hex row per word with CR LF, then EOF
// read address runs one row ahead of the row being sent
// tx_full_i stalls every counter

module file_dumper (
  input  logic                   clk_sys,
  input  logic                   rst_clk,
  input  logic                   dump_start_i,
  input  logic                   load_busy_i,
  input  logic                   tx_full_i,
  input  mem_cfg_pkg::mem_word_t rd_data_i,
  output mem_cfg_pkg::mem_addr_t rd_addr_o,
  output logic [7:0]             tx_data_o,
  output logic                   tx_we_o,
  output logic                   dump_busy_o,
  output logic                   dump_done_o
);

  file_io_pkg::dumper_state_e        state;
  logic [1:0]                        hdr_cnt;   // header character index
  logic [mem_cfg_pkg::ROW_CNT_W-1:0] row_cnt;   // position inside a row
  mem_cfg_pkg::mem_addr_t            word_cnt;  // row being sent
  logic [mem_cfg_pkg::NIB_CNT_W-1:0] nib_sel;
  logic [3:0]                        cur_nib;
  logic                              tx_go;     // character leaves this cycle

  // ************************************************************************
  // strobes and status
  // ************************************************************************

  // busy only while characters are due, low again in the done cycle
  assign dump_busy_o = (state == file_io_pkg::DP_HEADER) ||
                       (state == file_io_pkg::DP_ROW) ||
                       (state == file_io_pkg::DP_TRAILER);
  assign tx_go       = dump_busy_o && !tx_full_i;
  assign tx_we_o     = tx_go;
  assign dump_done_o = (state == file_io_pkg::DP_DONE);

  // digit select, msb nibble at row position 0
  assign nib_sel = row_cnt[mem_cfg_pkg::NIB_CNT_W-1:0];
  assign cur_nib = rd_data_i[(mem_cfg_pkg::NIBBLES - 1 - nib_sel) * 4 +: 4];

  // ************************************************************************
  // character mux
  // ************************************************************************

  always_comb
  begin
    tx_data_o = 8'h00;
    case (state)
      file_io_pkg::DP_HEADER:
        case (hdr_cnt)
          2'd0:    tx_data_o = file_io_pkg::SOH;
          2'd1:    tx_data_o = mem_cfg_pkg::FILE_ID;  // file name character
          2'd2:    tx_data_o = file_io_pkg::EOT;
          default: tx_data_o = file_io_pkg::SOT;
        endcase
      file_io_pkg::DP_ROW:
        if (row_cnt < mem_cfg_pkg::ROW_CR)
          tx_data_o = file_io_pkg::nibble_to_hex(cur_nib);
        else if (row_cnt == mem_cfg_pkg::ROW_CR)
          tx_data_o = file_io_pkg::CR;
        else
          tx_data_o = file_io_pkg::LF;
      file_io_pkg::DP_TRAILER:
        tx_data_o = file_io_pkg::EOF;
      default:
        tx_data_o = 8'h00;  // idle, done
    endcase
  end

  // ************************************************************************
  // FSM and counters
  // ************************************************************************

  always_ff @(posedge clk_sys)
  begin
    if (rst_clk)
    begin
      state     <= file_io_pkg::DP_IDLE;
      hdr_cnt   <= '0;
      row_cnt   <= '0;
      word_cnt  <= '0;
      rd_addr_o <= '0;
    end
    else
    begin
      case (state)
        file_io_pkg::DP_IDLE:
          if (dump_start_i && !load_busy_i)  // no dump over a half loaded memory
          begin
            state     <= file_io_pkg::DP_HEADER;
            hdr_cnt   <= '0;
            row_cnt   <= '0;
            word_cnt  <= '0;
            rd_addr_o <= '0;  // word 0 read during the header
          end
        file_io_pkg::DP_HEADER:
          if (tx_go)
          begin
            hdr_cnt <= hdr_cnt + 2'd1;
            if (hdr_cnt == 2'd3)
              state <= file_io_pkg::DP_ROW;
          end
        file_io_pkg::DP_ROW:
          if (tx_go)
          begin
            // next word in flight during CR LF
            if (row_cnt == mem_cfg_pkg::ROW_CR)
              rd_addr_o <= rd_addr_o + 1'b1;
            if (row_cnt == mem_cfg_pkg::ROW_LF)
            begin
              row_cnt  <= '0;
              word_cnt <= word_cnt + 1'b1;
              if (word_cnt == mem_cfg_pkg::ADDR_LAST)
                state <= file_io_pkg::DP_TRAILER;
            end
            else
            begin
              row_cnt <= row_cnt + 1'b1;
            end
          end
        file_io_pkg::DP_TRAILER:
          if (tx_go)
            state <= file_io_pkg::DP_DONE;
        file_io_pkg::DP_DONE:
          state <= file_io_pkg::DP_IDLE;  // one cycle, done pulse
        default:
          state <= file_io_pkg::DP_IDLE;
      endcase
    end
  end

  // back-pressure honoured at the port
  a_no_we_when_full : assert property (
    @(posedge clk_sys) disable iff (rst_clk)
    tx_full_i |-> !tx_we_o
  );

  // done is a single-cycle pulse
  a_done_pulse : assert property (
    @(posedge clk_sys) disable iff (rst_clk)
    dump_done_o |=> !dump_done_o
  );

endmodule

// ==== design/file_io_pkg.sv ====
// framing characters of the hex text file
// loader and dumper FSM state encodings
// ascii hex digit <-> nibble conversion

package file_io_pkg;

  // ************************************************************************
  // control characters
  // ************************************************************************

  typedef enum logic [7:0] {
    SOH = 8'h01,   // start of header
    SOT = 8'h02,   // start of text, opens a load
    EOT = 8'h03,   // end of header
    EOF = 8'h04,   // closes a dump
    LF  = 8'h0A,
    CR  = 8'h0D
  } ctrl_char_e;

  // ************************************************************************
  // FSM states
  // ************************************************************************

  typedef enum logic [1:0] {
    LD_IDLE,    // waiting for SOT
    LD_RECV,    // collecting hex digits
    LD_WRITE    // one cycle, word to memory
  } loader_state_e;

  typedef enum logic [2:0] {
    DP_IDLE,
    DP_HEADER,  // SOH, id, EOT, SOT
    DP_ROW,     // digits then CR LF
    DP_TRAILER, // EOF
    DP_DONE     // done pulse
  } dumper_state_e;

  // ************************************************************************
  // hex conversion
  // ************************************************************************

  // bit 4 set when ch is 0-9, A-F or a-f
  function automatic logic [4:0] hex_to_nibble(input logic [6:0] ch);
    logic [4:0] res;
    res = 5'b0_0000;
    if ((ch >= 7'h30) && (ch <= 7'h39))
      res = {1'b1, ch[3:0]};
    else if (((ch >= 7'h41) && (ch <= 7'h46)) || ((ch >= 7'h61) && (ch <= 7'h66)))
      res = {1'b1, ch[3:0] + 4'h9};  // low nibble of 'A'/'a' is 1, so 10..15
    return res;
  endfunction

  // upper case only
  function automatic logic [7:0] nibble_to_hex(input logic [3:0] nib);
    logic [7:0] ch;
    if (nib <= 4'h9)
      ch = {4'h3, nib};
    else
      ch = 8'h37 + {4'h0, nib};  // 'A' - 10
    return ch;
  endfunction

endpackage

// ==== design/file_io_top.sv ====
// hex text file port around one word memory
// loader fills the memory from rx characters
// dumper frames the memory contents out as tx characters

module file_io_top (
  input  logic       clk_sys,
  input  logic       rst_clk,
  input  logic [7:0] rx_data_i,
  input  logic       rx_valid_i,
  input  logic       dump_start_i,
  input  logic       tx_full_i,
  output logic [7:0] tx_data_o,
  output logic       tx_we_o,
  output logic       load_busy_o,
  output logic       dump_busy_o,
  output logic       dump_done_o
);

  // ************************************************************************
  // internal nets
  // ************************************************************************

  logic                   wr_en;    // loader -> memory
  mem_cfg_pkg::mem_addr_t wr_addr;
  mem_cfg_pkg::mem_word_t wr_data;
  mem_cfg_pkg::mem_addr_t rd_addr;  // dumper -> memory
  mem_cfg_pkg::mem_word_t rd_data;  // memory -> dumper, one cycle later
  logic                   load_busy;
  logic                   dump_busy;

  assign load_busy_o = load_busy;
  assign dump_busy_o = dump_busy;

  // receive parser
  file_loader file_loader_inst (
    .clk_sys     (clk_sys),
    .rst_clk     (rst_clk),
    .rx_data_i   (rx_data_i),
    .rx_valid_i  (rx_valid_i),
    .dump_busy_i (dump_busy),  // blocks a load during a dump
    .wr_en_o     (wr_en),
    .wr_addr_o   (wr_addr),
    .wr_data_o   (wr_data),
    .load_busy_o (load_busy)
  );

  // send framer
  file_dumper file_dumper_inst (
    .clk_sys      (clk_sys),
    .rst_clk      (rst_clk),
    .dump_start_i (dump_start_i),
    .load_busy_i  (load_busy),  // blocks a dump during a load
    .tx_full_i    (tx_full_i),
    .rd_data_i    (rd_data),
    .rd_addr_o    (rd_addr),
    .tx_data_o    (tx_data_o),
    .tx_we_o      (tx_we_o),
    .dump_busy_o  (dump_busy),
    .dump_done_o  (dump_done_o)
  );

  // storage
  word_mem word_mem_inst (
    .clk_sys   (clk_sys),
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

endmodule

// ==== design/file_loader.sv ====
// receive side of the file port
// waits for SOT, packs hex digits msb first into words
// writes MEM_DEPTH words in order, then goes back to idle

module file_loader (
  input  logic                   clk_sys,
  input  logic                   rst_clk,
  input  logic [7:0]             rx_data_i,
  input  logic                   rx_valid_i,
  input  logic                   dump_busy_i,
  output logic                   wr_en_o,
  output mem_cfg_pkg::mem_addr_t wr_addr_o,
  output mem_cfg_pkg::mem_word_t wr_data_o,
  output logic                   load_busy_o
);

  file_io_pkg::loader_state_e        state;
  logic [mem_cfg_pkg::NIB_CNT_W-1:0] nib_cnt;     // digit position in current word
  logic [4:0]                        hex_res;     // {valid, nibble}
  logic                              rx_take;     // character seen by this block
  logic                              hex_ok;
  logic                              addr_last;
  logic                              digit_take;  // digit goes into the word

  // ************************************************************************
  // character decode
  // ************************************************************************

  assign rx_take   = rx_valid_i && !dump_busy_i;  // deaf while a dump runs
  assign hex_res   = file_io_pkg::hex_to_nibble(rx_data_i[6:0]);
  assign hex_ok    = !rx_data_i[7] && hex_res[4];  // 8-bit chars are never digits
  assign addr_last = (wr_addr_o == mem_cfg_pkg::ADDR_LAST);

  // a digit may also land in the write cycle when another word follows
  assign digit_take = rx_take && hex_ok &&
                      ((state == file_io_pkg::LD_RECV) ||
                       ((state == file_io_pkg::LD_WRITE) && !addr_last));

  assign wr_en_o     = (state == file_io_pkg::LD_WRITE);
  assign load_busy_o = (state != file_io_pkg::LD_IDLE);

  // ************************************************************************
  // FSM, address and digit counters
  // ************************************************************************

  always_ff @(posedge clk_sys)
  begin
    if (rst_clk)
    begin
      state     <= file_io_pkg::LD_IDLE;
      nib_cnt   <= '0;
      wr_addr_o <= '0;
    end
    else
    begin
      case (state)
        file_io_pkg::LD_IDLE:
          if (rx_take && (rx_data_i == file_io_pkg::SOT))
          begin
            state     <= file_io_pkg::LD_RECV;
            nib_cnt   <= '0;
            wr_addr_o <= '0;  // every load starts at word 0
          end
        file_io_pkg::LD_RECV:
          if (digit_take)  // CR, LF, spaces, commas, a second SOT all fall through
          begin
            if (nib_cnt == mem_cfg_pkg::NIB_LAST)
            begin
              nib_cnt <= '0;
              state   <= file_io_pkg::LD_WRITE;
            end
            else
            begin
              nib_cnt <= nib_cnt + 1'b1;
            end
          end
        file_io_pkg::LD_WRITE:
          if (addr_last)
          begin
            state <= file_io_pkg::LD_IDLE;  // whole memory written
          end
          else
          begin
            wr_addr_o <= wr_addr_o + 1'b1;
            state     <= file_io_pkg::LD_RECV;
            // first digit of the next word already taken this cycle
            if (digit_take)
              nib_cnt <= {{(mem_cfg_pkg::NIB_CNT_W-1){1'b0}}, 1'b1};
            else
              nib_cnt <= '0;
          end
        default:
          state <= file_io_pkg::LD_IDLE;
      endcase
    end
  end

  // word assembly, msb digit first; old bits shift out over NIBBLES digits
  always_ff @(posedge clk_sys)
  begin
    if (digit_take)
    begin
      wr_data_o <= {wr_data_o[mem_cfg_pkg::MEM_WIDTH-5:0], hex_res[3:0]};
    end
  end

  // memory never written while the dumper reads it
  a_no_wr_during_dump : assert property (
    @(posedge clk_sys) disable iff (rst_clk)
    wr_en_o |-> !dump_busy_i
  );

endmodule

// ==== design/mem_cfg_pkg.sv ====
// memory geometry, address and word types
// counter widths and frame lengths of the dump

package mem_cfg_pkg;

  localparam int MEM_WIDTH = 32;               // bits per word
  localparam int MEM_DEPTH = 16;               // words
  localparam int ADDR_W    = $clog2(MEM_DEPTH);
  localparam int NIBBLES   = MEM_WIDTH / 4;    // hex digits per word
  localparam int ROW_LEN   = NIBBLES + 2;      // digits plus CR LF
  localparam int HDR_LEN   = 4;                // SOH id EOT SOT
  localparam int FRAME_LEN = HDR_LEN + MEM_DEPTH * ROW_LEN + 1;  // + EOF

  localparam logic [7:0] FILE_ID = 8'h30;      // ascii '0', single memory

  typedef logic [MEM_WIDTH-1:0] mem_word_t;
  typedef logic [ADDR_W-1:0]    mem_addr_t;

  // ************************************************************************
  // counter widths and terminal counts
  // ************************************************************************

  localparam int NIB_CNT_W = $clog2(NIBBLES);
  localparam int ROW_CNT_W = $clog2(ROW_LEN);

  localparam logic [NIB_CNT_W-1:0] NIB_LAST = NIB_CNT_W'(NIBBLES - 1);
  localparam logic [ROW_CNT_W-1:0] ROW_CR   = ROW_CNT_W'(NIBBLES);      // CR slot
  localparam logic [ROW_CNT_W-1:0] ROW_LF   = ROW_CNT_W'(NIBBLES + 1);  // last slot
  localparam mem_addr_t            ADDR_LAST = ADDR_W'(MEM_DEPTH - 1);

endpackage

// ==== design/word_mem.sv ====
// word memory, one write port and one registered read port
// read data one cycle after the address

module word_mem (
  input  logic                   clk_sys,
  input  logic                   wr_en_i,
  input  mem_cfg_pkg::mem_addr_t wr_addr_i,
  input  mem_cfg_pkg::mem_word_t wr_data_i,
  input  mem_cfg_pkg::mem_addr_t rd_addr_i,
  output mem_cfg_pkg::mem_word_t rd_data_o
);

  // storage, contents undefined until a load
  mem_cfg_pkg::mem_word_t mem_array [mem_cfg_pkg::MEM_DEPTH];

  // ************************************************************************
  // write and read ports
  // ************************************************************************

  always_ff @(posedge clk_sys)
  begin
    if (wr_en_i)
    begin
      mem_array[wr_addr_i] <= wr_data_i;
    end
    rd_data_o <= mem_array[rd_addr_i];  // old data on same-address collision
  end

  // a write to an unknown address would smear the whole array in simulation
  a_wr_addr_known : assert property (
    @(posedge clk_sys) wr_en_i |-> !$isunknown(wr_addr_i)
  );

endmodule

// ==== files.f ====
+incdir+include
design/file_io_pkg.sv
design/mem_cfg_pkg.sv
design/word_mem.sv
design/file_loader.sv
design/file_dumper.sv
design/file_io_top.sv
test/file_io_tb.sv

// ==== include/file_io_ref.svh ====
// reference model of the dump stream
// word to upper-case hex text, full expected frame from a model array

`ifndef FILE_IO_REF_SVH
`define FILE_IO_REF_SVH

typedef logic [7:0]             ref_row_t   [mem_cfg_pkg::NIBBLES];
typedef logic [7:0]             ref_frame_t [mem_cfg_pkg::FRAME_LEN];
typedef mem_cfg_pkg::mem_word_t ref_mem_t   [mem_cfg_pkg::MEM_DEPTH];

// one ascii digit, upper case
function automatic logic [7:0] ref_hex_char(input logic [3:0] nib);
  logic [7:0] ch;
  if (nib < 4'd10)
    ch = 8'h30 + {4'h0, nib};
  else
    ch = 8'h41 + {4'h0, nib} - 8'd10;
  return ch;
endfunction

// digits of one word, most significant first
function automatic ref_row_t ref_word_to_hex(input mem_cfg_pkg::mem_word_t word);
  ref_row_t row;
  for (int n = 0; n < mem_cfg_pkg::NIBBLES; n++)
    row[n] = ref_hex_char(word[(mem_cfg_pkg::NIBBLES - 1 - n) * 4 +: 4]);
  return row;
endfunction

// header, one row per word closed by CR LF, EOF
function automatic ref_frame_t ref_build_frame(input ref_mem_t model);
  ref_frame_t frame;
  ref_row_t   row;
  int         idx;
  frame[0] = file_io_pkg::SOH;
  frame[1] = mem_cfg_pkg::FILE_ID;
  frame[2] = file_io_pkg::EOT;
  frame[3] = file_io_pkg::SOT;
  idx = mem_cfg_pkg::HDR_LEN;
  for (int w = 0; w < mem_cfg_pkg::MEM_DEPTH; w++)
  begin
    row = ref_word_to_hex(model[w]);
    for (int n = 0; n < mem_cfg_pkg::NIBBLES; n++)
      frame[idx + n] = row[n];
    frame[idx + mem_cfg_pkg::NIBBLES]     = file_io_pkg::CR;
    frame[idx + mem_cfg_pkg::NIBBLES + 1] = file_io_pkg::LF;
    idx = idx + mem_cfg_pkg::ROW_LEN;
  end
  frame[idx] = file_io_pkg::EOF;  // idx is FRAME_LEN - 1 here
  return frame;
endfunction

`endif

// ==== test/file_io_tb.sv ====
// testbench for the hex text file port
// loads, noisy loads, dumps under back-pressure, load/dump exclusion
// posedge compare process against the reference frame

module file_io_tb;
  timeunit 1ns;
  timeprecision 1ps;

  `include "file_io_ref.svh"

  localparam int N_TESTS     = 5;
  localparam int TIMEOUT_CYC = N_TESTS * (mem_cfg_pkg::MEM_DEPTH * mem_cfg_pkg::ROW_LEN * 3 +
                               mem_cfg_pkg::FRAME_LEN * 4) + 1000;  // + margin

  logic       clk_sys, rst_clk;
  logic [7:0] rx_data_i;
  logic       rx_valid_i, dump_start_i, tx_full_i;
  logic [7:0] tx_data_o;
  logic       tx_we_o, load_busy_o, dump_busy_o, dump_done_o;

  ref_mem_t   model;        // what the memory should hold
  ref_frame_t exp_frame;    // expected dump
  logic [7:0] pre_sot [4];  // characters sent before any SOT
  int tx_count, done_count, err_cnt, test_base, pass_cnt, fail_cnt, cycle_cnt;

  file_io_top file_io_top_inst (.*);

  initial clk_sys = 1'b0;
  always #4 clk_sys = ~clk_sys;  // 8 ns

  // ************************************************************************
  // helpers
  // ************************************************************************

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  // ascii digit, lower case on request
  function automatic logic [7:0] digit_char(input logic [3:0] nib, input bit lower);
    if (nib < 4'd10)
      return 8'h30 + {4'h0, nib};
    return (lower ? 8'h61 : 8'h41) + {4'h0, nib} - 8'd10;
  endfunction

  task automatic send_char(input logic [7:0] c);
    @(negedge clk_sys);
    rx_data_i  = c;
    rx_valid_i = 1'b1;  // one-cycle strobe
    @(negedge clk_sys);
    rx_valid_i = 1'b0;
  endtask

  // SOT, then one row of digits per word, model follows the digits only
  task automatic load_file(input bit noise);
    mem_cfg_pkg::mem_word_t word;
    send_char(file_io_pkg::SOT);
    for (int w = 0; w < mem_cfg_pkg::MEM_DEPTH; w++)
    begin
      word     = $urandom;
      model[w] = word;
      for (int n = mem_cfg_pkg::NIBBLES - 1; n >= 0; n--)
      begin
        send_char(digit_char(word[n*4 +: 4], noise && ($urandom % 2 == 1)));
        if (noise && ($urandom % 4 == 0))
          send_char(($urandom % 2 == 1) ? 8'h20 : 8'h2C);  // space or comma
      end
      send_char(file_io_pkg::CR);
      send_char(file_io_pkg::LF);
    end
    while (load_busy_o)
      @(negedge clk_sys);
  endtask

  task automatic start_dump();
    exp_frame = ref_build_frame(model);
    tx_count  = 0;
    @(negedge clk_sys);
    dump_start_i = 1'b1;
    @(negedge clk_sys);
    dump_start_i = 1'b0;
  endtask

  // until the done pulse, optional random tx_full_i
  task automatic wait_dump(input bit backpressure);
    int base;
    base = done_count;
    while (done_count == base)
    begin
      @(negedge clk_sys);
      tx_full_i = backpressure && ($urandom % 3 == 0);
    end
    tx_full_i = 1'b0;
    check_value("tx strobes", tx_count, mem_cfg_pkg::FRAME_LEN);
    check_value("dump_done_o", dump_done_o, 0);  // single-cycle pulse
  endtask

  task automatic begin_test();
    test_base = err_cnt;
  endtask

  task automatic end_test(input int num, input string what);
    if (err_cnt == test_base)
    begin
      pass_cnt++;
      $display("test %0d %s: ok", num, what);
    end
    else
    begin
      fail_cnt++;
      $display("test %0d %s: failed, %0d errors", num, what, err_cnt - test_base);
    end
  endtask

  // ************************************************************************
  // compare process, timeout
  // ************************************************************************

  always @(posedge clk_sys)
  begin
    if (!rst_clk)
    begin
      if (tx_we_o && tx_full_i)
      begin
        $display("tx_we_o went high while tx_full_i was high");
        err_cnt++;
      end
      if (tx_we_o)
      begin
        if (tx_count < mem_cfg_pkg::FRAME_LEN)
          check_value("tx_data_o", tx_data_o, exp_frame[tx_count]);
        else
        begin
          $display("more tx_we_o strobes than one frame holds");
          err_cnt++;
        end
        tx_count++;
      end
      if (dump_done_o)
      begin
        check_value("tx strobes before dump_done_o", tx_count, mem_cfg_pkg::FRAME_LEN);
        check_value("dump_busy_o", dump_busy_o, 0);  // falls with done
        done_count++;
      end
    end
  end

  always @(posedge clk_sys)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYC)
    begin
      $display("run stopped, the DUT did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // ************************************************************************
  // tests
  // ************************************************************************

  initial
  begin
    void'($urandom(32'hac48_c206));
    {err_cnt, pass_cnt, fail_cnt, cycle_cnt, tx_count, done_count} = '0;
    rst_clk      = 1'b1;
    rx_data_i    = 8'h00;
    rx_valid_i   = 1'b0;
    dump_start_i = 1'b0;
    tx_full_i    = 1'b0;
    exp_frame    = ref_build_frame(model);
    pre_sot      = '{8'h31, 8'h41, 8'h66, 8'h0D};
    repeat (3) @(posedge clk_sys);
    @(negedge clk_sys);
    rst_clk = 1'b0;

    begin_test();  // idle after reset, digits without SOT
    check_value("tx_we_o", tx_we_o, 0);
    check_value("dump_done_o", dump_done_o, 0);
    check_value("load_busy_o", load_busy_o, 0);
    check_value("dump_busy_o", dump_busy_o, 0);
    foreach (pre_sot[i])
    begin
      send_char(pre_sot[i]);
      check_value("load_busy_o", load_busy_o, 0);
    end
    end_test(1, "reset and no load without SOT");

    begin_test();
    load_file(1'b0);
    start_dump();
    check_value("dump_busy_o", dump_busy_o, 1);  // one cycle after start
    wait_dump(1'b0);
    end_test(2, "round trip");

    begin_test();
    load_file(1'b1);
    start_dump();
    wait_dump(1'b0);
    end_test(3, "noisy load");

    begin_test();
    start_dump();
    wait_dump(1'b1);
    end_test(4, "back-pressure");

    begin_test();
    tx_count = 0;
    fork
      load_file(1'b0);
      begin
        while (!load_busy_o)
          @(negedge clk_sys);
        repeat (5) @(negedge clk_sys);
        dump_start_i = 1'b1;  // must be ignored
        @(negedge clk_sys);
        dump_start_i = 1'b0;
      end
    join
    check_value("tx strobes during load", tx_count, 0);
    start_dump();
    while (!dump_busy_o)
      @(negedge clk_sys);
    send_char(file_io_pkg::SOT);  // second file, memory must not change
    for (int i = 0; i < 4 * mem_cfg_pkg::NIBBLES; i++)
      send_char(digit_char(4'($urandom), 1'b0));
    wait_dump(1'b0);
    check_value("load_busy_o", load_busy_o, 0);
    start_dump();
    wait_dump(1'b0);
    end_test(5, "load and dump exclusion");

    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if ((fail_cnt == 0) && (err_cnt == 0))
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule
